//--- common/dma_bus_params.svh
/*
 * widths and defaults for the cpci dma bus controller
 * data width, queue count, length width, watchdog period, query word layout
 */

`ifndef DMA_BUS_PARAMS_SVH
`define DMA_BUS_PARAMS_SVH

// bus word between the cpci chip and the core
`define DMA_DATA_WIDTH 32

// cpu queues reported in a status query
`define NUM_CPU_QUEUES 4

// byte length field in the length word
`define PKT_LEN_CNT_WIDTH 11

`define WATCHDOG_TIMEOUT 62500  // idle cycles before a transfer is dropped

`define QUERY_AVAIL_LSB 16  // pkt avail field, nearly full sits at bit 0

`endif

//--- common/cpci_bus_pkg.sv
/*
 * pin side types of the dma link
 * op codes, bus word, queue id, sampled and driven pin bundles
 */

`default_nettype none

`include "dma_bus_params.svh"

package cpci_bus_pkg;

   typedef logic [`DMA_DATA_WIDTH-1:0] dma_word_t;
   typedef logic [3:0] queue_id_t;  // cpu queue number from the chip

   typedef enum logic [1:0] {
      idle         = 2'b00,
      status_query = 2'b01,
      transf_c2n   = 2'b10,  // cpci into the core
      transf_n2c   = 2'b11   // core out to cpci
   } op_code_e;

   // inputs from the chip, one sample per cycle
   typedef struct packed {
      op_code_e  op_code_req;
      queue_id_t queue_id;
      logic      vld;
      dma_word_t data;
      logic      dest_q_nearly_full;  // chip side can't take n2c data
   } cpci_c2n_t;

   // outputs to the chip
   typedef struct packed {
      op_code_e  op_code_ack;
      logic      vld;
      dma_word_t data;
      logic      data_tri_en;         // we own the data pins
      logic      dest_q_nearly_full;  // tx fifo almost full
   } cpci_n2c_t;

endpackage

`default_nettype wire

//--- common/cpu_fifo_pkg.sv
/*
 * core side types of the dma link
 * packet length, last word byte count, queue masks, tx fifo write bundle
 */

`default_nettype none

`include "dma_bus_params.svh"

package cpu_fifo_pkg;

   import cpci_bus_pkg::*;

   typedef logic [`PKT_LEN_CNT_WIDTH-1:0] pkt_len_t;  // bytes
   typedef logic [1:0] byte_cnt_t;  // 0 means all 4 bytes valid
   typedef logic [`NUM_CPU_QUEUES-1:0] queue_mask_t;

   // one tx fifo write
   // req format   is_req=1, type_eop 0 for c2n and 1 for n2c, data = queue id
   // data format  is_req=0, type_eop marks the last word
   typedef struct packed {
      logic      wr;
      logic      is_req;
      logic      pkt_vld;      // packet complete, only on the eop word
      logic      type_eop;
      byte_cnt_t valid_bytes;
      dma_word_t data;
   } txfifo_wr_t;

endpackage

`default_nettype wire

//--- dma_bus/dma_pin_capture.sv
/*
 * input register stage for the cpci pins
 */

`timescale 1ns/10ps
`default_nettype none

module dma_pin_capture
   import cpci_bus_pkg::*;
(
   input  wire logic      cpci_clk,
   input  wire cpci_c2n_t c2n_pins,  // straight from the chip
   output cpci_c2n_t      c2n_q      // one cycle later
);

   //////////////////////////////
   // sample stage
   //////////////////////////////

   // one flop on every input, the fsm never sees raw pins
   always_ff @(posedge cpci_clk) begin
      c2n_q <= c2n_pins;
   end

   //////////////////////////////
   // checks
   //////////////////////////////

   // chip drives a known op code once it leaves reset, x must not come back
   a_op_code_known: assert property (
      @(posedge cpci_clk)
      !$isunknown(c2n_q.op_code_req) |=> !$isunknown(c2n_q.op_code_req)
   ) else $error("op_code_req went unknown after a known value");

endmodule

`default_nettype wire

//--- dma_bus/dma_bus_fsm.sv
/*
 * transfer state machine of the dma bus
 * status query, c2n and n2c transfers, length counters, watchdog
 */

`timescale 1ns/10ps
`default_nettype none

`include "dma_bus_params.svh"

module dma_bus_fsm
   import cpci_bus_pkg::*, cpu_fifo_pkg::*;
#(
   parameter int unsigned watchdog_timeout = 62500
)(
   input  wire logic        cpci_clk,
   input  wire logic        cpci_reset,
   input  wire logic        enable_dma,
   input  wire cpci_c2n_t   c2n_q,
   input  wire queue_mask_t cpu_q_dma_pkt_avail,
   input  wire queue_mask_t cpu_q_dma_nearly_full,
   input  wire logic        rxfifo_empty,
   input  wire dma_word_t   rxfifo_rd_data,
   output txfifo_wr_t       tx_wr,
   output logic             rxfifo_rd_inc,
   output cpci_n2c_t        n2c_nxt,      // registered in the drive stage
   output logic             timeout_evt
);

   localparam int wd_width = $clog2(watchdog_timeout + 1);
   localparam dma_word_t fixed_word = dma_word_t'({`NUM_CPU_QUEUES{1'b1}});  // all full

   typedef enum logic [3:0] {
      st_idle, st_query,
      st_c2n_qid, st_c2n_len, st_c2n_data, st_c2n_done,
      st_n2c_qid, st_n2c_len, st_n2c_data, st_n2c_done,
      st_timeout_hold, st_timeout_query
   } state_e;

   state_e    state, state_nxt;
   op_code_e  ack_q, ack_nxt;
   logic      tri_en_q, tri_en_nxt;
   queue_id_t qid_q, qid_nxt;
   pkt_len_t  tx_len, tx_len_nxt;  // bytes still to come
   pkt_len_t  rx_len, rx_len_nxt;
   logic      vld_nxt;
   dma_word_t data_nxt;
   dma_word_t query_word;
   logic [wd_width-1:0] wd_cnt;
   logic      wd_expired, rx_ready;

   assign wd_expired = (wd_cnt == '0);
   assign rx_ready   = !rxfifo_empty && !c2n_q.dest_q_nearly_full;  // n2c may move

   // status word: pkt avail in the upper half, nearly full from bit 0
   always_comb begin
      query_word = '0;
      query_word[`QUERY_AVAIL_LSB +: `NUM_CPU_QUEUES] = cpu_q_dma_pkt_avail;
      query_word[`NUM_CPU_QUEUES-1:0] = cpu_q_dma_nearly_full;
   end

   //////////////////////////////
   // next state logic
   //////////////////////////////

   always_comb begin
      state_nxt     = state;
      ack_nxt       = ack_q;
      tri_en_nxt    = tri_en_q;
      qid_nxt       = qid_q;
      tx_len_nxt    = tx_len;
      rx_len_nxt    = rx_len;
      vld_nxt       = 1'b0;
      data_nxt      = '0;
      tx_wr         = '0;
      rxfifo_rd_inc = 1'b0;
      timeout_evt   = 1'b0;

      case (state)
         st_idle:
            if (enable_dma) begin
               case (c2n_q.op_code_req)
                  status_query: state_nxt = st_query;
                  transf_c2n:   state_nxt = st_c2n_qid;
                  transf_n2c:   state_nxt = st_n2c_qid;
                  default:      state_nxt = st_idle;
               endcase
            end
         st_query: begin
            ack_nxt    = status_query;
            tri_en_nxt = 1'b1;
            vld_nxt    = 1'b1;
            data_nxt   = enable_dma ? query_word : fixed_word;  // refreshed every cycle
            if (enable_dma && c2n_q.op_code_req == transf_c2n) state_nxt = st_c2n_qid;
            if (enable_dma && c2n_q.op_code_req == transf_n2c) state_nxt = st_n2c_qid;
         end
         st_c2n_qid, st_n2c_qid: begin
            // request word to the core, type_eop tells the direction
            tx_wr.wr       = 1'b1;
            tx_wr.is_req   = 1'b1;
            tx_wr.type_eop = (state == st_n2c_qid);
            tx_wr.data     = dma_word_t'(qid_q);
            ack_nxt    = (state == st_n2c_qid) ? transf_n2c : transf_c2n;
            tri_en_nxt = (state == st_n2c_qid);  // chip drives data on c2n
            rx_len_nxt = '0;
            state_nxt  = (state == st_n2c_qid) ? st_n2c_len : st_c2n_len;
         end
         st_c2n_len:
            if (wd_expired) begin
               state_nxt   = st_timeout_hold;
               timeout_evt = 1'b1;
            end else if (c2n_q.vld) begin
               tx_len_nxt     = c2n_q.data[`PKT_LEN_CNT_WIDTH-1:0];
               tx_wr.wr       = 1'b1;
               tx_wr.data     = c2n_q.data;
               tx_wr.type_eop = (tx_len_nxt == '0);  // empty packet ends here
               state_nxt      = (tx_len_nxt == '0) ? st_c2n_done : st_c2n_data;
            end
         st_c2n_data:
            if (wd_expired) begin
               state_nxt   = st_timeout_hold;
               timeout_evt = 1'b1;
            end else if (c2n_q.vld) begin
               tx_wr.wr   = 1'b1;
               tx_wr.data = c2n_q.data;
               if (tx_len <= 4) begin  // last word
                  tx_wr.type_eop    = 1'b1;
                  tx_wr.pkt_vld     = 1'b1;
                  tx_wr.valid_bytes = byte_cnt_t'(tx_len[1:0]);
                  tx_len_nxt        = '0;
                  state_nxt         = st_c2n_done;
               end else begin
                  tx_len_nxt = tx_len - pkt_len_t'(4);
               end
            end
         st_n2c_len:
            if (wd_expired) begin
               state_nxt   = st_timeout_hold;
               timeout_evt = 1'b1;
            end else if (rx_ready) begin
               rxfifo_rd_inc = 1'b1;
               vld_nxt       = 1'b1;
               data_nxt      = rxfifo_rd_data;
               rx_len_nxt    = rxfifo_rd_data[`PKT_LEN_CNT_WIDTH-1:0];
               state_nxt     = (rx_len_nxt == '0) ? st_n2c_done : st_n2c_data;
            end
         st_n2c_data:
            if (wd_expired) begin
               state_nxt   = st_timeout_hold;
               timeout_evt = 1'b1;
            end else if (rx_ready) begin
               rxfifo_rd_inc = 1'b1;
               vld_nxt       = 1'b1;
               data_nxt      = rxfifo_rd_data;
               if (rx_len <= 4) begin
                  rx_len_nxt = '0;
                  state_nxt  = st_n2c_done;
               end else begin
                  rx_len_nxt = rx_len - pkt_len_t'(4);
               end
            end
         st_c2n_done, st_n2c_done:
            // new query or the other direction, dma off falls to query
            if (!enable_dma) state_nxt = st_query;
            else if (c2n_q.op_code_req == status_query) state_nxt = st_query;
            else if (state == st_c2n_done && c2n_q.op_code_req == transf_n2c)
               state_nxt = st_n2c_qid;
            else if (state == st_n2c_done && c2n_q.op_code_req == transf_c2n)
               state_nxt = st_c2n_qid;
         st_timeout_hold:  // only a query gets out of here
            if (enable_dma && c2n_q.op_code_req == status_query)
               state_nxt = st_timeout_query;
         st_timeout_query: begin  // parked until reset
            ack_nxt    = status_query;
            tri_en_nxt = 1'b1;
            vld_nxt    = 1'b1;
            data_nxt   = fixed_word;
         end
         default: state_nxt = st_idle;
      endcase

      // queue id sampled with the op code that starts a transfer
      if (state_nxt inside {st_c2n_qid, st_n2c_qid}) qid_nxt = c2n_q.queue_id;

      n2c_nxt = '{op_code_ack: ack_nxt, vld: vld_nxt, data: data_nxt,
                  data_tri_en: tri_en_nxt, dest_q_nearly_full: 1'b0};
   end

   //////////////////////////////
   // registers
   //////////////////////////////

   always_ff @(posedge cpci_clk) begin
      if (cpci_reset) begin
         state    <= st_idle;
         ack_q    <= idle;
         tri_en_q <= 1'b0;
         tx_len   <= '0;
         rx_len   <= '0;
      end else begin
         state    <= state_nxt;
         ack_q    <= ack_nxt;
         tri_en_q <= tri_en_nxt;
         tx_len   <= tx_len_nxt;
         rx_len   <= rx_len_nxt;
      end
   end

   always_ff @(posedge cpci_clk) begin
      qid_q <= qid_nxt;
   end

   // watchdog, reloads on any forward progress (request words are tx writes too)
   always_ff @(posedge cpci_clk) begin
      if (cpci_reset || tx_wr.wr || vld_nxt) wd_cnt <= wd_width'(watchdog_timeout);
      else if (!wd_expired) wd_cnt <= wd_cnt - 1'b1;
   end

   a_rd_not_empty: assert property (
      @(posedge cpci_clk) disable iff (cpci_reset) rxfifo_rd_inc |-> !rxfifo_empty
   ) else $error("rx fifo read while empty");

   a_no_wr_in_hold: assert property (
      @(posedge cpci_clk) disable iff (cpci_reset)
      state inside {st_timeout_hold, st_timeout_query} |-> !tx_wr.wr
   ) else $error("tx fifo write after timeout");

endmodule

`default_nettype wire

//--- dma_bus/dma_pin_drive.sv
/*
 * output register stage for the cpci pins
 * adds the forwarded tx fifo nearly full flag and the timeout flag
 */

`timescale 1ns/10ps
`default_nettype none

module dma_pin_drive
   import cpci_bus_pkg::*;
(
   input  wire logic      cpci_clk,
   input  wire logic      cpci_reset,
   input  wire cpci_n2c_t n2c_nxt,
   input  wire logic      txfifo_nearly_full,
   input  wire logic      timeout_evt,
   output cpci_n2c_t      n2c_pins,
   output logic           timeout
);

   //////////////////////////////
   // pin registers
   //////////////////////////////

   always_ff @(posedge cpci_clk) begin
      if (cpci_reset) begin
         n2c_pins <= '{op_code_ack: idle, vld: 1'b0, data: '0,
                       data_tri_en: 1'b0, dest_q_nearly_full: 1'b0};
         timeout  <= 1'b0;
      end else begin
         n2c_pins.op_code_ack        <= n2c_nxt.op_code_ack;
         n2c_pins.vld                <= n2c_nxt.vld;
         n2c_pins.data               <= n2c_nxt.data;
         n2c_pins.data_tri_en        <= n2c_nxt.data_tri_en;
         n2c_pins.dest_q_nearly_full <= txfifo_nearly_full;  // fsm leaves this 0
         timeout                     <= timeout_evt;          // one cycle pulse
      end
   end

   // data valid only while we own the bus
   a_vld_needs_tri_en: assert property (
      @(posedge cpci_clk) disable iff (cpci_reset)
      n2c_pins.vld |-> n2c_pins.data_tri_en
   ) else $error("n2c vld with data pins released");

endmodule

`default_nettype wire

//--- dma_bus/dma_bus_top.sv
/*
 * dma bus controller top level
 * pin capture, transfer fsm and pin drive stages
 */

`timescale 1ns/10ps
`default_nettype none

`include "dma_bus_params.svh"

module dma_bus_top
   import cpci_bus_pkg::*, cpu_fifo_pkg::*;
#(
   parameter int unsigned watchdog_timeout = `WATCHDOG_TIMEOUT
)(
   input  wire logic        cpci_clk,
   input  wire logic        cpci_reset,
   input  wire logic        enable_dma,
   // cpci chip
   input  wire cpci_c2n_t   c2n_pins,
   output cpci_n2c_t        n2c_pins,
   output logic             timeout,
   // core side fifos
   input  wire queue_mask_t cpu_q_dma_pkt_avail,
   input  wire queue_mask_t cpu_q_dma_nearly_full,
   input  wire logic        txfifo_nearly_full,
   output txfifo_wr_t       tx_wr,
   input  wire logic        rxfifo_empty,
   output logic             rxfifo_rd_inc,
   input  wire dma_word_t   rxfifo_rd_data
);

   cpci_c2n_t c2n_q;        // sampled pins
   cpci_n2c_t n2c_nxt;      // fsm outputs ahead of the pin flops
   logic      timeout_evt;

   dma_pin_capture i_dma_pin_capture (
      .cpci_clk (cpci_clk), .c2n_pins (c2n_pins), .c2n_q (c2n_q)
   );

   dma_bus_fsm #(.watchdog_timeout(watchdog_timeout)) i_dma_bus_fsm (
      .cpci_clk, .cpci_reset, .enable_dma, .c2n_q,
      .cpu_q_dma_pkt_avail, .cpu_q_dma_nearly_full, .rxfifo_empty, .rxfifo_rd_data,
      .tx_wr, .rxfifo_rd_inc, .n2c_nxt, .timeout_evt
   );

   dma_pin_drive i_dma_pin_drive (
      .cpci_clk, .cpci_reset, .n2c_nxt, .txfifo_nearly_full, .timeout_evt,
      .n2c_pins, .timeout
   );

endmodule

`default_nettype wire

//--- testbench/tb_dma_bus.sv
/*
 * testbench for the dma bus controller
 * clock, fifo models, reference functions, compare tasks, watchdog
 */

`timescale 1ns/10ps
`default_nettype none

`include "dma_bus_params.svh"

module tb_dma_bus
   import cpci_bus_pkg::*, cpu_fifo_pkg::*;
();

   localparam int num_pkts  = 8;
   localparam int wd_cycles = 64;               // dut watchdog, short for sim
   localparam int max_words = 2 * num_pkts * 18 + 60;  // req + len + 16 data per packet

   logic        cpci_clk;
   logic        cpci_reset;
   logic        enable_dma;
   cpci_c2n_t   c2n_pins;
   cpci_n2c_t   n2c_pins;
   logic        timeout;
   queue_mask_t cpu_q_dma_pkt_avail;
   queue_mask_t cpu_q_dma_nearly_full;
   logic        txfifo_nearly_full;
   txfifo_wr_t  tx_wr;
   logic        rxfifo_empty;
   logic        rxfifo_rd_inc;
   dma_word_t   rxfifo_rd_data;

   txfifo_wr_t  exp_tx[$];   // tx fifo sink, expected writes in order
   dma_word_t   exp_n2c[$];  // words due on the pins
   dma_word_t   rx_q[$];     // rx fifo contents
   logic [31:0] main_seed = 32'h3b07;
   logic [31:0] rx_seed   = 32'h3b07 ^ 32'h0000_5a5a;
   logic [31:0] nf_seed   = 32'h3b07 ^ 32'h0000_a5a5;
   queue_mask_t avail_m;
   queue_mask_t nf_m;
   int          timeout_cnt = 0;
   logic        nf_last;
   logic        nf_armed = 1'b0;

   dma_bus_top #(.watchdog_timeout(wd_cycles)) i_dma_bus_top (
      .cpci_clk, .cpci_reset, .enable_dma, .c2n_pins, .n2c_pins, .timeout,
      .cpu_q_dma_pkt_avail, .cpu_q_dma_nearly_full, .txfifo_nearly_full,
      .tx_wr, .rxfifo_empty, .rxfifo_rd_inc, .rxfifo_rd_data
   );

   initial begin
      cpci_clk = 1'b0;
      forever #2 cpci_clk = ~cpci_clk;  // 4 ns
   end

   //////////////////////////////
   // reference model
   //////////////////////////////

   function automatic logic [31:0] lcg_next(inout logic [31:0] s);
      s = s * 32'd1664525 + 32'd1013904223;
      return s >> 8;  // low bits are poor
   endfunction

   // fixed word when dma is off or after a timeout
   function automatic dma_word_t expect_query(input queue_mask_t avail,
                                              input queue_mask_t nf, input logic live);
      dma_word_t w;
      w = '0;
      if (live) begin
         w[`QUERY_AVAIL_LSB +: `NUM_CPU_QUEUES] = avail;
         w[`NUM_CPU_QUEUES-1:0] = nf;
      end else begin
         w[`NUM_CPU_QUEUES-1:0] = '1;  // nothing available, all nearly full
      end
      return w;
   endfunction

   function automatic txfifo_wr_t expect_req(input queue_id_t qid, input logic n2c);
      txfifo_wr_t t;
      t          = '0;
      t.wr       = 1'b1;
      t.is_req   = 1'b1;
      t.type_eop = n2c;  // direction flag
      t.data     = dma_word_t'(qid);
      return t;
   endfunction

   // idx -1 is the length word, data words count from 0
   function automatic txfifo_wr_t expect_tx_word(input pkt_len_t len, input int idx,
                                                 input dma_word_t d);
      txfifo_wr_t t;
      int rem;
      t    = '0;
      t.wr = 1'b1;
      t.data = d;
      rem  = int'(len) - 4 * idx;  // bytes left incl this word
      if (idx < 0) begin
         t.type_eop = (len == 0);
      end else if (rem <= 4) begin  // last word
         t.type_eop    = 1'b1;
         t.pkt_vld     = 1'b1;
         t.valid_bytes = byte_cnt_t'(rem % 4);
      end
      return t;
   endfunction

   //////////////////////////////
   // checks
   //////////////////////////////

   task automatic fail_test(input string msg);
      $display("FAILED at %0t ns: %s", $time, msg);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_tx_wr(input txfifo_wr_t got, input txfifo_wr_t exp);
      if (got !== exp) fail_test($sformatf("tx write %h, expected %h", got, exp));
   endtask

   task automatic check_n2c_word(input dma_word_t got, input dma_word_t exp);
      if (got !== exp) fail_test($sformatf("pin word %h, expected %h", got, exp));
   endtask

   task automatic check_ack(input op_code_e got, input op_code_e exp);
      if (got !== exp) fail_test($sformatf("ack %s, expected %s", got.name(), exp.name()));
   endtask

   // compare process, outputs are settled at the falling edge
   always @(negedge cpci_clk) begin
      if (!cpci_reset) begin
         if (tx_wr.wr) begin
            if (exp_tx.size() == 0) fail_test("tx fifo written with no write expected");
            else check_tx_wr(tx_wr, exp_tx.pop_front());
         end
         if (n2c_pins.vld && n2c_pins.op_code_ack == transf_n2c) begin
            if (exp_n2c.size() == 0) fail_test("n2c word on the pins with none expected");
            else check_n2c_word(n2c_pins.data, exp_n2c.pop_front());
         end
         if (rxfifo_rd_inc && rxfifo_empty) fail_test("rx fifo read while empty");
         if (timeout) timeout_cnt++;
         if (nf_armed && n2c_pins.dest_q_nearly_full !== nf_last)
            fail_test("tx nearly full flag not on the pins one cycle later");
         nf_last  = txfifo_nearly_full;
         nf_armed = 1'b1;
      end
   end

   //////////////////////////////
   // fifo models
   //////////////////////////////

   initial begin
      logic take;
      rxfifo_empty   = 1'b1;
      rxfifo_rd_data = '0;
      forever begin
         @(negedge cpci_clk);
         take = rxfifo_rd_inc;
         @(posedge cpci_clk);
         if (take) rx_q.delete(0);  // consumed word
         rxfifo_empty   <= (rx_q.size() == 0) || (lcg_next(rx_seed) % 4 == 0);
         rxfifo_rd_data <= (rx_q.size() != 0) ? rx_q[0] : '0;
      end
   end

   initial begin
      txfifo_nearly_full = 1'b0;
      forever begin
         @(posedge cpci_clk);
         txfifo_nearly_full <= (lcg_next(nf_seed) % 3 == 0);
      end
   end

   //////////////////////////////
   // sequences
   //////////////////////////////

   task automatic wait_ack(input op_code_e op);
      int n;
      n = 0;
      @(negedge cpci_clk);
      while (n2c_pins.op_code_ack !== op) begin
         n++;
         if (n > 50) fail_test($sformatf("no %s ack from the dut", op.name()));
         @(negedge cpci_clk);
      end
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (exp_tx.size() != 0 || exp_n2c.size() != 0) begin
         @(posedge cpci_clk);
         n++;
         if (n > 1000) fail_test("expected fifo or pin words never arrived");
      end
      @(posedge cpci_clk);
   endtask

   task automatic check_query(input dma_word_t exp);
      repeat (2) @(posedge cpci_clk);
      @(negedge cpci_clk);
      check_ack(n2c_pins.op_code_ack, status_query);
      if (!(n2c_pins.vld && n2c_pins.data_tri_en)) fail_test("query word not driven");
      check_n2c_word(n2c_pins.data, exp);
   endtask

   task automatic run_query(input logic live);
      @(posedge cpci_clk);
      avail_m = queue_mask_t'(lcg_next(main_seed));
      nf_m    = queue_mask_t'(lcg_next(main_seed));
      cpu_q_dma_pkt_avail   <= avail_m;
      cpu_q_dma_nearly_full <= nf_m;
      c2n_pins.op_code_req  <= status_query;
      wait_ack(status_query);
      check_query(expect_query(avail_m, nf_m, live));
   endtask

   task automatic run_c2n(input pkt_len_t len, input queue_id_t qid);
      dma_word_t w;
      @(posedge cpci_clk);
      c2n_pins.op_code_req <= transf_c2n;
      c2n_pins.queue_id    <= qid;
      exp_tx.push_back(expect_req(qid, 1'b0));
      wait_ack(transf_c2n);  // fsm now waits for the length word
      for (int i = -1; i < (int'(len) + 3) / 4; i++) begin
         while (lcg_next(main_seed) % 4 == 0) begin  // idle gap on the pins
            @(posedge cpci_clk);
            c2n_pins.vld <= 1'b0;
         end
         w = (i < 0) ? dma_word_t'(len) : dma_word_t'(lcg_next(main_seed));
         @(posedge cpci_clk);
         c2n_pins.vld  <= 1'b1;
         c2n_pins.data <= w;
         exp_tx.push_back(expect_tx_word(len, i, w));
      end
      @(posedge cpci_clk);
      c2n_pins.vld <= 1'b0;
      wait_drained();
   endtask

   task automatic run_n2c(input pkt_len_t len, input queue_id_t qid);
      dma_word_t w;
      int n;
      n = 0;
      @(negedge cpci_clk);  // fill the rx fifo away from the model's edge
      for (int i = -1; i < (int'(len) + 3) / 4; i++) begin
         w = (i < 0) ? dma_word_t'(len) : dma_word_t'(lcg_next(main_seed));
         rx_q.push_back(w);
         exp_n2c.push_back(w);
      end
      exp_tx.push_back(expect_req(qid, 1'b1));
      @(posedge cpci_clk);
      c2n_pins.op_code_req <= transf_n2c;
      c2n_pins.queue_id    <= qid;
      while (exp_n2c.size() != 0) begin  // chip side throttles at random
         @(posedge cpci_clk);
         c2n_pins.dest_q_nearly_full <= (lcg_next(main_seed) % 4 == 0);
         n++;
         if (n > 1000) fail_test("n2c words stopped arriving on the pins");
      end
      @(posedge cpci_clk);
      c2n_pins.dest_q_nearly_full <= 1'b0;
      wait_drained();
   endtask

   initial begin
      pkt_len_t len;
      int n;
      cpci_reset            = 1'b1;
      enable_dma            = 1'b0;
      c2n_pins              = '0;
      cpu_q_dma_pkt_avail   = '0;
      cpu_q_dma_nearly_full = '0;
      repeat (4) @(posedge cpci_clk);
      cpci_reset <= 1'b0;
      enable_dma <= 1'b1;

      for (int p = 0; p < num_pkts; p++) begin
         run_query(1'b1);
         len = (p == 0) ? '0 : pkt_len_t'(lcg_next(main_seed) % 64 + 1);  // first one empty
         run_c2n(len, queue_id_t'(p));
         run_query(1'b1);
         len = (p == 1) ? '0 : pkt_len_t'(lcg_next(main_seed) % 64 + 1);
         run_n2c(len, queue_id_t'(15 - p));
      end

      // dma off gives the fixed word
      run_query(1'b1);
      @(posedge cpci_clk);
      enable_dma <= 1'b0;
      check_query(expect_query(avail_m, nf_m, 1'b0));
      @(posedge cpci_clk);
      enable_dma <= 1'b1;

      // c2n stalled after its length word
      @(posedge cpci_clk);
      c2n_pins.op_code_req <= transf_c2n;
      c2n_pins.queue_id    <= 4'd3;
      exp_tx.push_back(expect_req(4'd3, 1'b0));
      wait_ack(transf_c2n);
      @(posedge cpci_clk);
      c2n_pins.vld  <= 1'b1;
      c2n_pins.data <= 32'd16;
      exp_tx.push_back(expect_tx_word(11'd16, -1, 32'd16));
      @(posedge cpci_clk);
      c2n_pins.vld <= 1'b0;
      n = 0;
      while (timeout_cnt == 0) begin
         @(posedge cpci_clk);
         n++;
         if (n > 4 * wd_cycles) fail_test("dut watchdog never fired on the stalled transfer");
      end
      if (exp_tx.size() != 0) fail_test("tx words missing before the timeout");

      // parked, only the fixed status answer
      run_query(1'b0);
      @(posedge cpci_clk);
      c2n_pins.op_code_req <= transf_c2n;
      c2n_pins.vld         <= 1'b1;
      repeat (20) @(posedge cpci_clk);  // any tx write here trips the monitor
      c2n_pins.vld <= 1'b0;
      check_query(expect_query(avail_m, nf_m, 1'b0));

      if (timeout_cnt != 1) begin
         fail_test($sformatf("timeout high for %0d cycles, expected 1", timeout_cnt));
      end else begin
         $display("PASS: all tests");
         $finish;
      end
   end

   // run limit from the worst case word count
   initial begin
      repeat (max_words * 40 + 2000) @(posedge cpci_clk);
      $display("simulation hung, the tests did not finish in time");
      $display("FAIL: see errors above");
      $fatal(1, "testbench watchdog expired");
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/cpci_bus_pkg.sv
common/cpu_fifo_pkg.sv
dma_bus/dma_pin_capture.sv
dma_bus/dma_bus_fsm.sv
dma_bus/dma_pin_drive.sv
dma_bus/dma_bus_top.sv
testbench/tb_dma_bus.sv

//--- Bender.yml
package:
  name: dma_bus

sources:
  - include_dirs:
      - common
    files:
      - common/cpci_bus_pkg.sv
      - common/cpu_fifo_pkg.sv
      - dma_bus/dma_pin_capture.sv
      - dma_bus/dma_bus_fsm.sv
      - dma_bus/dma_pin_drive.sv
      - dma_bus/dma_bus_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_dma_bus.sv
